//--- src/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   typedef enum logic [2:0] {
      REGION_CARTRIDGE = 3'd0,
      REGION_LCDRAM    = 3'd1,
      REGION_WRAM      = 3'd2,
      REGION_OAM       = 3'd3,
      REGION_IOREG     = 3'd4,
      REGION_LWRAM     = 3'd5,
      REGION_NONE      = 3'd7   // Gaps with no slave behind them
   } region_t;

   // LO bounds are inclusive, HI bounds exclusive
   localparam addr_t CARTRIDGE_LO = 16'h0000;
   localparam addr_t CARTRIDGE_HI = 16'h8000;
   localparam addr_t LCDRAM_LO    = 16'h8000;
   localparam addr_t LCDRAM_HI    = 16'hA000;
   localparam addr_t WRAM_LO      = 16'hC000;
   localparam addr_t WRAM_HI      = 16'hE000;
   localparam addr_t OAM_LO       = 16'hFE00;
   localparam addr_t OAM_HI       = 16'hFEA0;
   localparam addr_t IOREG_LO     = 16'hFF00;
   localparam addr_t IOREG_HI     = 16'hFF80;
   localparam addr_t LWRAM_LO     = 16'hFF80;
   localparam addr_t LWRAM_HI     = 16'hFFFF;   // 0xFFFF stays unmapped

   localparam int NUM_REGIONS  = 6;             // Mapped regions, codes 0 to 5
   localparam int REGION_SLOTS = 8;             // Every 3-bit region code

   // Lookup tables indexed by region code, unused codes hold an empty range
   localparam logic [REGION_SLOTS-1:0][15:0] REGION_LO = {
      16'h0000, 16'h0000, LWRAM_LO, IOREG_LO, OAM_LO, WRAM_LO, LCDRAM_LO, CARTRIDGE_LO
   };
   localparam logic [REGION_SLOTS-1:0][15:0] REGION_HI = {
      16'h0000, 16'h0000, LWRAM_HI, IOREG_HI, OAM_HI, WRAM_HI, LCDRAM_HI, CARTRIDGE_HI
   };

   localparam data_t OPEN_BUS_DATA = 8'hFF;     // Read data of any errored access

endpackage

`default_nettype wire

//--- src/router_pkg.sv
`default_nettype none

package router_pkg;

   typedef struct packed {
      mem_map_pkg::addr_t addr;
      logic               we;      // 1 = write
      mem_map_pkg::data_t wdata;
   } mem_req_t;

   typedef struct packed {
      mem_map_pkg::data_t rdata;
      logic               error;   // Unmapped or forbidden access
   } mem_rsp_t;

   typedef enum logic {
      MASTER_CPU = 1'b0,
      MASTER_PPU = 1'b1
   } master_t;

   typedef struct packed {
      master_t              master;
      mem_map_pkg::region_t region;
      mem_map_pkg::addr_t   offset;  // Address minus region LO bound
      logic                 we;
      mem_map_pkg::data_t   wdata;
      logic                 error;
   } routed_access_t;

   typedef struct packed {
      logic                 valid;
      mem_map_pkg::region_t region;
      mem_map_pkg::addr_t   offset;
      logic                 we;
      mem_map_pkg::data_t   wdata;
   } slave_cmd_t;

   typedef enum logic [1:0] {
      PORT_IDLE    = 2'd0,
      PORT_PENDING = 2'd1,
      PORT_ACK     = 2'd2
   } port_state_t;

   typedef enum logic [1:0] {
      SEQ_IDLE    = 2'd0,
      SEQ_ISSUE   = 2'd1,
      SEQ_CAPTURE = 2'd2
   } seq_state_t;

   localparam int QUEUE_DEPTH = 2;
   localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage

`default_nettype wire

//--- src/master_port.sv
`default_nettype none

module master_port (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  router_pkg::mem_req_t cmd_in,
   input  logic                 grant,
   input  logic                 done,
   input  router_pkg::mem_rsp_t rsp_in,
   output logic                 ack,
   output router_pkg::mem_rsp_t rsp,
   output logic                 pending,
   output router_pkg::mem_req_t cmd
);

   import router_pkg::*;

   port_state_t state;
   port_state_t state_next;
   logic        issued;   // Request already taken by the decoder

   always_comb begin
      state_next = state;
      case (state)
         PORT_IDLE: begin
            if (req)
               state_next = PORT_PENDING;   // New request from the master
         end
         PORT_PENDING: begin
            if (done)
               state_next = PORT_ACK;
         end
         PORT_ACK: begin
            if (!req)
               state_next = PORT_IDLE;      // Master saw ack, finish the handshake
         end
         default: state_next = PORT_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= PORT_IDLE;
         issued <= 1'b0;
      end else begin
         state <= state_next;
         if (state == PORT_IDLE)
            issued <= 1'b0;
         else if (grant)
            issued <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state == PORT_IDLE && req)
         cmd <= cmd_in;                     // Held until the next request
      if (done)
         rsp <= rsp_in;
   end

   assign pending = (state == PORT_PENDING) && !issued;
   assign ack     = (state == PORT_ACK);

endmodule

`default_nettype wire

//--- src/access_decoder.sv
`default_nettype none

module access_decoder (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       cpu_pending,
   input  logic                       ppu_pending,
   input  router_pkg::mem_req_t       cpu_cmd,
   input  router_pkg::mem_req_t       ppu_cmd,
   input  logic                       full,
   output logic                       cpu_grant,
   output logic                       ppu_grant,
   output logic                       push,
   output router_pkg::routed_access_t entry
);

   import mem_map_pkg::*;
   import router_pkg::*;

   master_t  last_grant;   // Loses the next tie
   logic     can_grant;
   logic     pick_ppu;
   logic     granted;
   master_t  sel_master;
   mem_req_t sel_cmd;
   region_t  region;
   addr_t    offset;
   logic     error;

   // An entry still on its way into the queue is not counted in full yet
   assign can_grant = !full && !push;

   assign pick_ppu   = ppu_pending && (!cpu_pending || last_grant == MASTER_CPU);
   assign cpu_grant  = can_grant && cpu_pending && !pick_ppu;
   assign ppu_grant  = can_grant && pick_ppu;
   assign granted    = cpu_grant || ppu_grant;
   assign sel_master = pick_ppu ? MASTER_PPU : MASTER_CPU;
   assign sel_cmd    = pick_ppu ? ppu_cmd : cpu_cmd;

   // Region lookup against the map table
   always_comb begin
      region = REGION_NONE;
      for (int i = 0; i < NUM_REGIONS; i++) begin
         if (sel_cmd.addr >= REGION_LO[i] && sel_cmd.addr < REGION_HI[i])
            region = region_t'(i[2:0]);
      end
   end

   assign offset = sel_cmd.addr - REGION_LO[region];

   // PPU only reaches LCD RAM and OAM
   assign error = (region == REGION_NONE) ||
                  (sel_master == MASTER_PPU && region != REGION_LCDRAM &&
                   region != REGION_OAM);

   always_ff @(posedge clk) begin
      if (reset) begin
         push       <= 1'b0;
         last_grant <= MASTER_PPU;   // CPU wins the first tie
      end else begin
         push <= granted;
         if (granted)
            last_grant <= sel_master;
      end
   end

   always_ff @(posedge clk) begin
      if (granted) begin
         entry.master <= sel_master;
         entry.region <= region;
         entry.offset <= offset;
         entry.we     <= sel_cmd.we;
         entry.wdata  <= sel_cmd.wdata;
         entry.error  <= error;
      end
   end

endmodule

`default_nettype wire

//--- src/access_queue.sv
`default_nettype none

module access_queue (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       push,
   input  router_pkg::routed_access_t push_entry,
   input  logic                       pop,
   output router_pkg::routed_access_t head,
   output logic                       full,
   output logic                       empty
);

   import router_pkg::*;

   routed_access_t         mem [QUEUE_DEPTH];
   logic [QUEUE_PTR_W-1:0] wr_ptr;
   logic [QUEUE_PTR_W-1:0] rd_ptr;
   logic [QUEUE_CNT_W-1:0] count;
   logic                   do_push;
   logic                   do_pop;

   function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
      if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1))
         return '0;                       // Wrap for any depth
      return ptr + 1'b1;
   endfunction

   assign do_push = push && !full;        // Push into a full queue is dropped
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_entry;
   end

   assign head  = mem[rd_ptr];
   assign full  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
   assign empty = (count == '0);

endmodule

`default_nettype wire

//--- src/slave_sequencer.sv
`default_nettype none

module slave_sequencer (
   input  logic                       clk,
   input  logic                       reset,
   input  router_pkg::routed_access_t head,
   input  logic                       empty,
   input  mem_map_pkg::data_t         slave_rdata,
   output logic                       pop,
   output router_pkg::slave_cmd_t     slave_cmd,
   output logic                       cpu_done,
   output logic                       ppu_done,
   output router_pkg::mem_rsp_t       rsp
);

   import mem_map_pkg::*;
   import router_pkg::*;

   seq_state_t     state;
   seq_state_t     state_next;
   routed_access_t cur;    // Access being run
   logic           done;

   assign pop = (state == SEQ_IDLE) && !empty;

   always_comb begin
      state_next = state;
      case (state)
         SEQ_IDLE: begin
            if (!empty)
               state_next = head.error ? SEQ_CAPTURE : SEQ_ISSUE;   // Errors skip the bus
         end
         SEQ_ISSUE:   state_next = SEQ_CAPTURE;
         SEQ_CAPTURE: state_next = SEQ_IDLE;
         default:     state_next = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= SEQ_IDLE;
      else
         state <= state_next;
   end

   always_ff @(posedge clk) begin
      if (pop)
         cur <= head;
   end

   // Command fields come straight from registers, valid only in the issue cycle
   always_comb begin
      slave_cmd.valid  = (state == SEQ_ISSUE);
      slave_cmd.region = cur.region;
      slave_cmd.offset = cur.offset;
      slave_cmd.we     = cur.we;
      slave_cmd.wdata  = cur.wdata;
   end

   assign done     = (state == SEQ_CAPTURE);
   assign cpu_done = done && (cur.master == MASTER_CPU);
   assign ppu_done = done && (cur.master == MASTER_PPU);

   // Slave returns read data in the capture cycle
   always_comb begin
      if (cur.error) begin
         rsp.rdata = OPEN_BUS_DATA;
         rsp.error = 1'b1;
      end else if (cur.we) begin
         rsp.rdata = '0;
         rsp.error = 1'b0;
      end else begin
         rsp.rdata = slave_rdata;
         rsp.error = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/memory_router.sv
`default_nettype none

module memory_router (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cpu_req,
   input  router_pkg::mem_req_t   cpu_cmd,
   input  logic                   ppu_req,
   input  router_pkg::mem_req_t   ppu_cmd,
   input  mem_map_pkg::data_t     slave_rdata,
   output logic                   cpu_ack,
   output router_pkg::mem_rsp_t   cpu_rsp,
   output logic                   ppu_ack,
   output router_pkg::mem_rsp_t   ppu_rsp,
   output router_pkg::slave_cmd_t slave_cmd
);

   import router_pkg::*;

   logic           cpu_pending;
   logic           ppu_pending;
   mem_req_t       cpu_port_cmd;    // Command held by each port
   mem_req_t       ppu_port_cmd;
   logic           cpu_grant;
   logic           ppu_grant;
   logic           push;
   routed_access_t push_entry;
   logic           full;
   logic           empty;
   routed_access_t head;
   logic           pop;
   logic           cpu_done;
   logic           ppu_done;
   mem_rsp_t       seq_rsp;         // Shared by both ports, qualified by done

   master_port cpu_port (
      .clk     (clk),
      .reset   (reset),
      .req     (cpu_req),
      .cmd_in  (cpu_cmd),
      .grant   (cpu_grant),
      .done    (cpu_done),
      .rsp_in  (seq_rsp),
      .ack     (cpu_ack),
      .rsp     (cpu_rsp),
      .pending (cpu_pending),
      .cmd     (cpu_port_cmd)
   );

   master_port ppu_port (
      .clk     (clk),
      .reset   (reset),
      .req     (ppu_req),
      .cmd_in  (ppu_cmd),
      .grant   (ppu_grant),
      .done    (ppu_done),
      .rsp_in  (seq_rsp),
      .ack     (ppu_ack),
      .rsp     (ppu_rsp),
      .pending (ppu_pending),
      .cmd     (ppu_port_cmd)
   );

   access_decoder access_decoder_inst (
      .clk         (clk),
      .reset       (reset),
      .cpu_pending (cpu_pending),
      .ppu_pending (ppu_pending),
      .cpu_cmd     (cpu_port_cmd),
      .ppu_cmd     (ppu_port_cmd),
      .full        (full),
      .cpu_grant   (cpu_grant),
      .ppu_grant   (ppu_grant),
      .push        (push),
      .entry       (push_entry)
   );

   access_queue access_queue_inst (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_entry (push_entry),
      .pop        (pop),
      .head       (head),
      .full       (full),
      .empty      (empty)
   );

   slave_sequencer slave_sequencer_inst (
      .clk         (clk),
      .reset       (reset),
      .head        (head),
      .empty       (empty),
      .slave_rdata (slave_rdata),
      .pop         (pop),
      .slave_cmd   (slave_cmd),
      .cpu_done    (cpu_done),
      .ppu_done    (ppu_done),
      .rsp         (seq_rsp)
   );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`default_nettype none

module clock_gen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 16;

   initial begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;                // Released on a rising edge
   end

   always #4 clk = ~clk;            // 8 ns period

endmodule

`default_nettype wire

//--- testbench/memory_router_tb.sv
`default_nettype none

module memory_router_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import mem_map_pkg::*;
   import router_pkg::*;

   localparam int          TIMEOUT_CYCLES = 64;
   localparam int          STREAM_PAIRS   = 8;
   localparam logic [31:0] SEED           = 32'hd285728b;

   logic       clk;
   logic       reset;
   logic       cpu_req;
   logic       ppu_req;
   mem_req_t   cpu_cmd;
   mem_req_t   ppu_cmd;
   data_t      slave_rdata = '0;
   logic       cpu_ack;
   logic       ppu_ack;
   mem_rsp_t   cpu_rsp;
   mem_rsp_t   ppu_rsp;
   slave_cmd_t slave_cmd;
   addr_t      slave_addr;

   data_t   slave_mem [65536];          // Slave storage
   data_t   shadow [65536];             // Reference copy of every byte
   region_t mapped [6] = '{REGION_CARTRIDGE, REGION_LCDRAM, REGION_WRAM,
                           REGION_OAM, REGION_IOREG, REGION_LWRAM};
   region_t cpu_regions [4] = '{REGION_CARTRIDGE, REGION_WRAM, REGION_IOREG, REGION_LWRAM};
   region_t ppu_regions [2] = '{REGION_LCDRAM, REGION_OAM};
   region_t ppu_forbidden [3] = '{REGION_WRAM, REGION_IOREG, REGION_CARTRIDGE};
   addr_t   gap_lo [4] = '{16'hA000, 16'hE000, 16'hFEA0, 16'hFFFF};
   int      gap_span [4] = '{32'h2000, 32'h1E00, 32'h60, 1};

   clock_gen clock_gen_inst (.clk(clk), .reset(reset));

   memory_router memory_router_inst (
      .clk         (clk),
      .reset       (reset),
      .cpu_req     (cpu_req),
      .cpu_cmd     (cpu_cmd),
      .ppu_req     (ppu_req),
      .ppu_cmd     (ppu_cmd),
      .slave_rdata (slave_rdata),
      .cpu_ack     (cpu_ack),
      .cpu_rsp     (cpu_rsp),
      .ppu_ack     (ppu_ack),
      .ppu_rsp     (ppu_rsp),
      .slave_cmd   (slave_cmd)
   );

   function automatic data_t fill_byte(addr_t a);
      return a[15:8] ^ {a[3:0], a[7:4]} ^ 8'h5A;
   endfunction

   function automatic addr_t region_lo(region_t r);
      case (r)
         REGION_LCDRAM: return 16'h8000;
         REGION_WRAM:   return 16'hC000;
         REGION_OAM:    return 16'hFE00;
         REGION_IOREG:  return 16'hFF00;
         REGION_LWRAM:  return 16'hFF80;
         default:       return 16'h0000;
      endcase
   endfunction

   function automatic addr_t region_hi(region_t r);
      case (r)
         REGION_CARTRIDGE: return 16'h8000;
         REGION_LCDRAM:    return 16'hA000;
         REGION_WRAM:      return 16'hE000;
         REGION_OAM:       return 16'hFEA0;
         REGION_IOREG:     return 16'hFF80;
         REGION_LWRAM:     return 16'hFFFF;   // Last byte is a hole
         default:          return 16'h0000;
      endcase
   endfunction

   function automatic region_t expect_region(addr_t a);
      region_t r;
      r = REGION_NONE;
      foreach (mapped[i]) begin
         if (a >= region_lo(mapped[i]) && a < region_hi(mapped[i]))
            r = mapped[i];
      end
      return r;
   endfunction

   function automatic addr_t random_in(addr_t lo, int unsigned span);
      return lo + addr_t'($urandom % span);
   endfunction

   function automatic addr_t random_addr(region_t r);
      return random_in(region_lo(r), int'(region_hi(r)) - int'(region_lo(r)));
   endfunction

   // Slave answers a read one cycle after the valid command
   assign slave_addr = region_lo(slave_cmd.region) + slave_cmd.offset;

   always @(posedge clk) begin
      if (slave_cmd.valid) begin
         if (slave_cmd.we)
            slave_mem[slave_addr] <= slave_cmd.wdata;
         else
            slave_rdata <= slave_mem[slave_addr];
      end
   end

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_value(input string test_name, input int expected, input int actual);
      assert (expected == actual)
      else fail_run($sformatf("[ERROR] %s expected %0h actual %0h", test_name, expected, actual));
   endtask

   assert property (@(posedge clk) disable iff (reset) $rose(cpu_ack) |-> cpu_req)
   else fail_run("cpu_ack rose while cpu_req was low");
   assert property (@(posedge clk) disable iff (reset) $rose(ppu_ack) |-> ppu_req)
   else fail_run("ppu_ack rose while ppu_req was low");
   assert property (@(posedge clk) disable iff (reset) cpu_ack && cpu_req |=> cpu_ack)
   else fail_run("cpu_ack fell before cpu_req was released");
   assert property (@(posedge clk) disable iff (reset) ppu_ack && ppu_req |=> ppu_ack)
   else fail_run("ppu_ack fell before ppu_req was released");
   assert property (@(posedge clk) disable iff (reset) cpu_ack && !cpu_req |=> !cpu_ack)
   else fail_run("cpu_ack stayed high after cpu_req fell");
   assert property (@(posedge clk) disable iff (reset) ppu_ack && !ppu_req |=> !ppu_ack)
   else fail_run("ppu_ack stayed high after ppu_req fell");
   assert property (@(posedge clk) disable iff (reset) slave_cmd.valid |=> !slave_cmd.valid)
   else fail_run("slave command valid held for two cycles");

   // One four-phase transaction, slave commands counted on falling edges
   task automatic run_access(input master_t m, input addr_t address, input logic we,
                             input data_t wdata, output mem_rsp_t rsp, output int cmd_count,
                             output slave_cmd_t seen_cmd);
      int   cycles;
      logic ack_now;
      @(posedge clk);
      if (m == MASTER_CPU) begin
         cpu_cmd <= '{addr: address, we: we, wdata: wdata};
         cpu_req <= 1'b1;
      end else begin
         ppu_cmd <= '{addr: address, we: we, wdata: wdata};
         ppu_req <= 1'b1;
      end
      cycles    = 0;
      cmd_count = 0;
      seen_cmd  = '0;
      ack_now   = 1'b0;
      while (!ack_now) begin
         @(negedge clk);
         ack_now = (m == MASTER_CPU) ? cpu_ack : ppu_ack;
         if (slave_cmd.valid) begin
            cmd_count++;
            seen_cmd = slave_cmd;
         end
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            fail_run($sformatf("%s ack never rose for address %h", m.name(), address));
      end
      rsp = (m == MASTER_CPU) ? cpu_rsp : ppu_rsp;
      @(posedge clk);
      if (m == MASTER_CPU)
         cpu_req <= 1'b0;
      else
         ppu_req <= 1'b0;
      cycles = 0;
      while (ack_now) begin
         @(negedge clk);
         ack_now = (m == MASTER_CPU) ? cpu_ack : ppu_ack;
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            fail_run($sformatf("%s ack never fell for address %h", m.name(), address));
      end
   endtask

   task automatic check_access(input string test_name, input master_t m, input addr_t a,
                               input logic we, input data_t wdata, input logic check_bus);
      region_t    exp_region;
      logic       exp_error;
      data_t      exp_rdata;
      mem_rsp_t   rsp;
      int         cmd_count;
      slave_cmd_t seen_cmd;
      exp_region = expect_region(a);
      exp_error  = (exp_region == REGION_NONE) || (m == MASTER_PPU &&
                   exp_region != REGION_LCDRAM && exp_region != REGION_OAM);
      if (exp_error)
         exp_rdata = 8'hFF;
      else if (we)
         exp_rdata = 8'h00;
      else
         exp_rdata = shadow[a];
      run_access(m, a, we, wdata, rsp, cmd_count, seen_cmd);
      check_value({test_name, " error"}, exp_error, rsp.error);
      check_value({test_name, " rdata"}, exp_rdata, rsp.rdata);
      if (check_bus) begin
         check_value({test_name, " slave commands"}, exp_error ? 0 : 1, cmd_count);
         if (!exp_error) begin
            check_value({test_name, " region"}, exp_region, seen_cmd.region);
            check_value({test_name, " offset"}, a - region_lo(exp_region), seen_cmd.offset);
            check_value({test_name, " we"}, we, seen_cmd.we);
            if (we)
               check_value({test_name, " wdata"}, wdata, seen_cmd.wdata);
         end
      end
      if (we && !exp_error)
         shadow[a] = wdata;
   endtask

   initial begin
      addr_t a;
      int    cycles;
      void'($urandom(SEED));
      cpu_req = 1'b0;
      ppu_req = 1'b0;
      cpu_cmd = '0;
      ppu_cmd = '0;
      for (int i = 0; i < 65536; i++) begin
         slave_mem[i] = fill_byte(addr_t'(i));
         shadow[i]    = fill_byte(addr_t'(i));
      end
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            fail_run("Reset was never released");
      end while (reset);
      check_value("after_reset", 0, {cpu_ack, ppu_ack, slave_cmd.valid});

      foreach (mapped[i]) begin
         repeat (2) begin
            a = random_addr(mapped[i]);
            check_access("cpu_write_read", MASTER_CPU, a, 1'b1, data_t'($urandom), 1'b1);
            check_access("cpu_write_read", MASTER_CPU, a, 1'b0, 8'h00, 1'b1);
         end
      end

      foreach (gap_lo[i]) begin
         a = random_in(gap_lo[i], gap_span[i]);
         check_access("cpu_unmapped", MASTER_CPU, a, 1'b0, 8'h00, 1'b1);
         check_access("cpu_unmapped", MASTER_CPU, a, 1'b1, data_t'($urandom), 1'b1);
      end

      foreach (ppu_regions[i]) begin
         a = random_addr(ppu_regions[i]);
         check_access("ppu_shared", MASTER_CPU, a, 1'b1, data_t'($urandom), 1'b1);
         check_access("ppu_shared", MASTER_PPU, a, 1'b0, 8'h00, 1'b1);
         check_access("ppu_shared", MASTER_PPU, a, 1'b1, data_t'($urandom), 1'b1);
         check_access("ppu_shared", MASTER_PPU, a, 1'b0, 8'h00, 1'b1);
      end
      foreach (ppu_forbidden[i]) begin
         a = random_addr(ppu_forbidden[i]);
         check_access("ppu_forbidden", MASTER_PPU, a, 1'b0, 8'h00, 1'b1);
         check_access("ppu_forbidden", MASTER_PPU, a, 1'b1, data_t'($urandom), 1'b1);
      end

      // Both masters compete for the queue, address sets kept apart
      fork
         begin : cpu_stream
            addr_t ca;
            for (int n = 0; n < STREAM_PAIRS; n++) begin
               ca = random_addr(cpu_regions[$urandom % 4]);
               check_access("overlap_cpu", MASTER_CPU, ca, 1'b1, data_t'($urandom), 1'b0);
               check_access("overlap_cpu", MASTER_CPU, ca, 1'b0, 8'h00, 1'b0);
            end
         end
         begin : ppu_stream
            addr_t pa;
            for (int n = 0; n < STREAM_PAIRS; n++) begin
               pa = random_addr(ppu_regions[$urandom % 2]);
               check_access("overlap_ppu", MASTER_PPU, pa, 1'b1, data_t'($urandom), 1'b0);
               check_access("overlap_ppu", MASTER_PPU, pa, 1'b0, 8'h00, 1'b0);
            end
         end
      join

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
src/mem_map_pkg.sv
src/router_pkg.sv
src/master_port.sv
src/access_decoder.sv
src/access_queue.sv
src/slave_sequencer.sv
src/memory_router.sv
testbench/clock_gen.sv
testbench/memory_router_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memory_router_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=
PASS_MSG  ?= ALL CHECKS PASSED

COMMON = --timing --assert --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON)

build:
	$(VERILATOR) --binary $(COMMON) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
